//--- common/softmax_pkg.sv
`default_nettype none

package softmax_pkg;

  // group geometry
  localparam int NUM_NODES  = 8;
  localparam int NODE_CNT_W = $clog2(NUM_NODES + 1);
  localparam int NODE_IDX_W = $clog2(NUM_NODES);

  // datapath widths
  localparam int COEF_W     = 4;
  localparam int EXP_W      = 16;
  localparam int SUM_W      = 19;
  localparam int ALPHA_FRAC = 8;
  localparam int ALPHA_W    = ALPHA_FRAC + 1;

  // one stage per quotient bit plus the output register
  localparam int DIV_LAT    = ALPHA_W + 1;
  // partial remainder is below the divisor, one extra bit for the shift
  localparam int DIV_REM_W  = SUM_W + 1;

  // pairwise reduction tree depth
  localparam int RED_STEPS  = $clog2(NUM_NODES);
  localparam int RED_STEP_W = $clog2(RED_STEPS + 1);

  // boundary flow control
  localparam int IN_DEPTH    = 2;
  localparam int IN_PTR_W    = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int IN_CNT_W    = $clog2(IN_DEPTH + 1);
  localparam int OUT_CREDITS = 2;
  localparam int CRED_W      = $clog2(OUT_CREDITS + 1);

  typedef struct packed {
    logic [NODE_CNT_W-1:0]             count;
    logic [NUM_NODES-1:0][COEF_W-1:0]  coef;
  } coef_group_t;

  typedef struct packed {
    logic [NODE_CNT_W-1:0]             count;
    logic [NUM_NODES-1:0][ALPHA_W-1:0] alpha;
  } alpha_group_t;

  typedef struct packed {
    logic [EXP_W-1:0]      dividend;
    logic [SUM_W-1:0]      divisor;
    logic [NODE_IDX_W-1:0] idx;
  } div_req_t;

  typedef struct packed {
    logic [ALPHA_W-1:0]    quot;
    logic [NODE_IDX_W-1:0] idx;
  } div_rsp_t;

  typedef enum logic [2:0] {
    SM_IDLE,
    SM_EXP,
    SM_REDUCE,
    SM_ISSUE,
    SM_COLLECT
  } sm_state_t;

endpackage

`default_nettype wire

//--- logic/coef_ingress.sv
`timescale 1ns/1ps
`default_nettype none

module coef_ingress import softmax_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        i_in_valid,
  input  wire coef_group_t i_in_group,
  input  wire logic        i_ready,
  output logic             o_in_credit,
  output logic             o_valid,
  output coef_group_t      o_group
);

  coef_group_t         mem [IN_DEPTH];
  logic [IN_PTR_W-1:0] wr_ptr_q;
  logic [IN_PTR_W-1:0] rd_ptr_q;
  logic [IN_CNT_W-1:0] count_q;
  logic                push;
  logic                pop;

  assign push = i_in_valid;
  assign pop  = o_valid && i_ready;

  // head of queue goes straight to the engine
  assign o_valid = (count_q != '0);
  assign o_group = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= i_in_group;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      o_in_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == IN_PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == IN_PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // slot freed, hand one credit back upstream
      o_in_credit <= pop;
    end
  end

  // upstream may only send while it holds a credit, so full means a violation
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    i_in_valid |-> (count_q < IN_CNT_W'(IN_DEPTH))
  );

endmodule

`default_nettype wire

//--- softmax/fxp_div_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module fxp_div_pipe import softmax_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     i_valid,
  input  wire div_req_t i_req,
  output logic          o_valid,
  output div_rsp_t      o_rsp
);

  // stage registers, one quotient bit resolved per stage
  logic [DIV_REM_W-1:0]  rem_q   [ALPHA_W];
  logic [ALPHA_W-1:0]    quot_q  [ALPHA_W];
  logic [SUM_W-1:0]      dvs_q   [ALPHA_W];
  logic [NODE_IDX_W-1:0] idx_q   [ALPHA_W];
  logic [ALPHA_W-1:0]    vld_q;

  // stage inputs and next values
  logic [DIV_REM_W-1:0]  rem_in  [ALPHA_W];
  logic [ALPHA_W-1:0]    quot_in [ALPHA_W];
  logic [SUM_W-1:0]      dvs_in  [ALPHA_W];
  logic [NODE_IDX_W-1:0] idx_in  [ALPHA_W];
  logic [ALPHA_W-1:0]    vld_in;
  logic [DIV_REM_W-1:0]  rem_nx  [ALPHA_W];
  logic [ALPHA_W-1:0]    quot_nx [ALPHA_W];

  always_comb begin
    // first stage takes the integer bit, so no shift on entry
    rem_in[0]  = DIV_REM_W'(i_req.dividend);
    quot_in[0] = '0;
    dvs_in[0]  = i_req.divisor;
    idx_in[0]  = i_req.idx;
    vld_in[0]  = i_valid;
    for (int s = 1; s < ALPHA_W; s++) begin
      rem_in[s]  = rem_q[s-1] << 1;
      quot_in[s] = quot_q[s-1];
      dvs_in[s]  = dvs_q[s-1];
      idx_in[s]  = idx_q[s-1];
      vld_in[s]  = vld_q[s-1];
    end
    // restoring step, subtract when the partial remainder covers the divisor
    for (int s = 0; s < ALPHA_W; s++) begin
      quot_nx[s] = quot_in[s];
      if (rem_in[s] >= DIV_REM_W'(dvs_in[s])) begin
        rem_nx[s]                = rem_in[s] - DIV_REM_W'(dvs_in[s]);
        quot_nx[s][ALPHA_W-1-s] = 1'b1;
      end else begin
        rem_nx[s]                = rem_in[s];
        quot_nx[s][ALPHA_W-1-s] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int s = 0; s < ALPHA_W; s++) begin
      rem_q[s]  <= rem_nx[s];
      quot_q[s] <= quot_nx[s];
      dvs_q[s]  <= dvs_in[s];
      idx_q[s]  <= idx_in[s];
    end
    o_rsp.quot <= quot_q[ALPHA_W-1];
    o_rsp.idx  <= idx_q[ALPHA_W-1];
  end

  // valid shift chain alongside the data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q   <= '0;
      o_valid <= 1'b0;
    end else begin
      vld_q   <= vld_in;
      o_valid <= vld_q[ALPHA_W-1];
    end
  end

  // the engine must have a nonzero group sum before it issues
  a_divisor_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n)
    i_valid |-> (i_req.divisor != '0)
  );

endmodule

`default_nettype wire

//--- softmax/softmax_engine.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_engine import softmax_pkg::*; (
  input  wire logic         clk,
  input  wire logic         rst_n,
  input  wire logic         i_valid,
  input  wire coef_group_t  i_group,
  input  wire logic         i_ready,
  output logic              o_ready,
  output logic              o_valid,
  output alpha_group_t      o_group
);

  sm_state_t                         state_q;
  sm_state_t                         state_d;
  logic                              ready_q;
  logic [RED_STEP_W-1:0]             red_step_q;
  logic [NODE_IDX_W-1:0]             issue_idx_q;
  logic [NODE_CNT_W-1:0]             rsp_cnt_q;

  logic [NODE_CNT_W-1:0]             cnt_q;
  logic [NUM_NODES-1:0][COEF_W-1:0]  coef_q;
  logic [NUM_NODES-1:0][EXP_W-1:0]   term_q;
  logic [NUM_NODES-1:0][SUM_W-1:0]   red_q;
  logic [NUM_NODES-1:0][ALPHA_W-1:0] alpha_q;

  logic                              accept;
  logic                              out_fire;
  logic                              last_issue;
  logic                              div_valid;
  div_req_t                          div_req;
  logic                              rsp_valid;
  div_rsp_t                          div_rsp;

  assign accept     = i_valid && ready_q;
  assign out_fire   = o_valid && i_ready;
  assign last_issue = (NODE_CNT_W'(issue_idx_q) == cnt_q - NODE_CNT_W'(1));

  assign o_ready = ready_q;
  // group is complete once every issued divide has come back
  assign o_valid       = (state_q == SM_COLLECT) && (rsp_cnt_q == cnt_q);
  assign o_group.count = cnt_q;
  assign o_group.alpha = alpha_q;

  // one divide per cycle, sum sits in slot 0 after the reduction
  assign div_valid        = (state_q == SM_ISSUE);
  assign div_req.dividend = term_q[issue_idx_q];
  assign div_req.divisor  = red_q[0];
  assign div_req.idx      = issue_idx_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      SM_IDLE:    if (accept) state_d = SM_EXP;
      SM_EXP:     state_d = SM_REDUCE;
      SM_REDUCE:  if (red_step_q == RED_STEP_W'(RED_STEPS - 1)) state_d = SM_ISSUE;
      SM_ISSUE:   if (last_issue) state_d = SM_COLLECT;
      SM_COLLECT: if (out_fire) state_d = SM_IDLE;
      default:    state_d = SM_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q     <= SM_IDLE;
      ready_q     <= 1'b0;
      red_step_q  <= '0;
      issue_idx_q <= '0;
      rsp_cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == SM_IDLE);
      if (state_q == SM_REDUCE) begin
        red_step_q <= red_step_q + 1'b1;
      end else begin
        red_step_q <= '0;
      end
      if (accept) begin
        issue_idx_q <= '0;
      end else if (div_valid) begin
        issue_idx_q <= issue_idx_q + 1'b1;
      end
      if (accept) begin
        rsp_cnt_q <= '0;
      end else if (rsp_valid) begin
        rsp_cnt_q <= rsp_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cnt_q  <= i_group.count;
      coef_q <= i_group.coef;
    end
    // exp(c) approximated as 2^c, unused slots forced to zero
    if (state_q == SM_EXP) begin
      for (int i = 0; i < NUM_NODES; i++) begin
        if (NODE_CNT_W'(i) < cnt_q) begin
          term_q[i] <= EXP_W'(1) << coef_q[i];
          red_q[i]  <= SUM_W'(EXP_W'(1) << coef_q[i]);
        end else begin
          term_q[i] <= '0;
          red_q[i]  <= '0;
        end
      end
    end
    // halve the array every cycle
    if (state_q == SM_REDUCE) begin
      for (int i = 0; i < NUM_NODES / 2; i++) begin
        red_q[i] <= red_q[2*i] + red_q[2*i+1];
      end
      for (int i = NUM_NODES / 2; i < NUM_NODES; i++) begin
        red_q[i] <= '0;
      end
    end
    // clear on accept so a smaller group leaves nothing stale
    if (accept) begin
      alpha_q <= '0;
    end else if (rsp_valid) begin
      alpha_q[div_rsp.idx] <= div_rsp.quot;
    end
  end

  fxp_div_pipe u_div (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (div_valid),
    .i_req   (div_req),
    .o_valid (rsp_valid),
    .o_rsp   (div_rsp)
  );

  a_count_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    accept |-> (i_group.count >= 1 && i_group.count <= NUM_NODES)
  );

  // quotients only come back for a group that is being divided
  a_rsp_in_window: assert property (
    @(posedge clk) disable iff (!rst_n)
    rsp_valid |-> (state_q inside {SM_ISSUE, SM_COLLECT})
  );

endmodule

`default_nettype wire

//--- logic/alpha_egress.sv
`timescale 1ns/1ps
`default_nettype none

module alpha_egress import softmax_pkg::*; (
  input  wire logic         clk,
  input  wire logic         rst_n,
  input  wire logic         i_valid,
  input  wire alpha_group_t i_group,
  input  wire logic         i_out_credit,
  output logic              o_ready,
  output logic              o_out_valid,
  output alpha_group_t      o_out_group
);

  alpha_group_t      data_q;
  logic              full_q;
  logic              full_d;
  logic              ready_q;
  logic [CRED_W-1:0] cred_q;
  logic              accept;
  logic              send;

  assign accept = i_valid && ready_q;
  // only release while downstream has room
  assign send   = full_q && (cred_q != '0);
  assign full_d = (full_q && !send) || accept;

  assign o_ready     = ready_q;
  assign o_out_valid = send;
  assign o_out_group = data_q;

  always_ff @(posedge clk) begin
    if (accept) begin
      data_q <= i_group;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full_q  <= 1'b0;
      ready_q <= 1'b0;
      cred_q  <= CRED_W'(OUT_CREDITS);
    end else begin
      full_q  <= full_d;
      ready_q <= !full_d;
      // a returning credit and a send in one cycle cancel out
      case ({i_out_credit, send})
        2'b10:   cred_q <= cred_q + 1'b1;
        2'b01:   cred_q <= cred_q - 1'b1;
        default: cred_q <= cred_q;
      endcase
    end
  end

  // downstream never returns more than it was given
  a_credit_bound: assert property (
    @(posedge clk) disable iff (!rst_n)
    cred_q <= CRED_W'(OUT_CREDITS)
  );

endmodule

`default_nettype wire

//--- logic/gat_softmax_top.sv
`timescale 1ns/1ps
`default_nettype none

module gat_softmax_top import softmax_pkg::*; (
  input  wire logic         clk,
  input  wire logic         rst_n,
  input  wire logic         i_in_valid,
  input  wire coef_group_t  i_in_group,
  input  wire logic         i_out_credit,
  output logic              o_in_credit,
  output logic              o_out_valid,
  output alpha_group_t      o_out_group
);

  logic         ing_valid;
  coef_group_t  ing_group;
  logic         eng_ready;
  logic         eng_valid;
  alpha_group_t eng_group;
  logic         egr_ready;

  coef_ingress u_ingress (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_in_valid  (i_in_valid),
    .i_in_group  (i_in_group),
    .i_ready     (eng_ready),
    .o_in_credit (o_in_credit),
    .o_valid     (ing_valid),
    .o_group     (ing_group)
  );

  softmax_engine u_engine (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (ing_valid),
    .i_group (ing_group),
    .i_ready (egr_ready),
    .o_ready (eng_ready),
    .o_valid (eng_valid),
    .o_group (eng_group)
  );

  alpha_egress u_egress (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_valid      (eng_valid),
    .i_group      (eng_group),
    .i_out_credit (i_out_credit),
    .o_ready      (egr_ready),
    .o_out_valid  (o_out_valid),
    .o_out_group  (o_out_group)
  );

endmodule

`default_nettype wire

//--- tb/tb_softmax_ref.svh
`ifndef TB_SOFTMAX_REF_SVH
`define TB_SOFTMAX_REF_SVH

localparam logic [31:0] LFSR_SEED = 32'ha7ac_23be;
// x^32 + x^22 + x^2 + x + 1, right-shifting form
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

// expected groups in send order, read back by output index
alpha_group_t exp_q[$];

// softmax with 2^c standing in for exp(c), quotient truncated
function automatic alpha_group_t ref_alpha(input coef_group_t g);
  alpha_group_t    r;
  longint unsigned sum;
  longint unsigned term;
  r = '0;
  r.count = g.count;
  sum = 0;
  for (int i = 0; i < g.count; i++) begin
    sum += longint'(1) << g.coef[i];
  end
  for (int i = 0; i < g.count; i++) begin
    term = longint'(1) << g.coef[i];
    r.alpha[i] = ALPHA_W'((term << ALPHA_FRAC) / sum);
  end
  return r;
endfunction

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
endfunction

// one lfsr step per bit taken
task automatic take_bits(inout logic [31:0] state, input int n, output int unsigned val);
  val = 0;
  for (int b = 0; b < n; b++) begin
    state = lfsr_next(state);
    val = (val << 1) | int'(state[0]);
  end
endtask

function automatic void push_expected(input alpha_group_t a);
  exp_q.push_back(a);
endfunction

function automatic alpha_group_t expected_at(input int idx);
  return exp_q[idx];
endfunction

`endif

//--- tb/tb_gat_softmax.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gat_softmax import softmax_pkg::*; ();

  localparam int N_SINGLE  = 6;
  localparam int N_FULL    = 20;
  localparam int N_PART    = 30;
  localparam int N_EQUAL   = 8;
  localparam int N_BP      = 8;
  localparam int N_B2B     = 16;
  localparam int N_TOTAL   = N_SINGLE + N_FULL + N_PART + N_EQUAL + N_BP + N_B2B;
  localparam int BP_HOLD   = 300;
  localparam int WD_CYCLES = N_TOTAL * (NUM_NODES + DIV_LAT + 20) + BP_HOLD + 500;

  logic         clk;
  logic         rst_n;
  logic         in_valid;
  coef_group_t  in_group;
  logic         out_credit;
  logic         in_credit;
  logic         out_valid;
  alpha_group_t out_group;

  logic [31:0]  stim_lfsr;
  logic [31:0]  cred_lfsr = 32'ha7ac_23be;
  logic         hold_credits;
  logic         prompt_credits;
  int           sent_cnt = 0;
  int           outs_seen = 0;
  int           in_credits_rcvd = 0;
  int           credits_seen = 0;
  int           credits_sent = 0;
  int           chk_errs = 0;
  int           stim_errs = 0;

  `include "tb_softmax_ref.svh"

  gat_softmax_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_in_valid   (in_valid),
    .i_in_group   (in_group),
    .i_out_credit (out_credit),
    .o_in_credit  (in_credit),
    .o_out_valid  (out_valid),
    .o_out_group  (out_group)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int errors_now();
    return chk_errs + stim_errs;
  endfunction

  task automatic random_group(input int cnt, input bit same, output coef_group_t g);
    int unsigned v;
    g = '0;
    g.count = NODE_CNT_W'(cnt);
    take_bits(stim_lfsr, COEF_W, v);
    // slots above the count get junk too
    for (int i = 0; i < NUM_NODES; i++) begin
      if (!same) take_bits(stim_lfsr, COEF_W, v);
      g.coef[i] = COEF_W'(v);
    end
  endtask

  task automatic send_group(input coef_group_t g, input alpha_group_t e, input bit gaps);
    int unsigned gap;
    // upstream credit model
    while (IN_DEPTH + in_credits_rcvd - sent_cnt <= 0) begin
      @(posedge clk);
      #1;
    end
    in_valid = 1'b1;
    in_group = g;
    push_expected(e);
    sent_cnt++;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    if (gaps) begin
      take_bits(stim_lfsr, 2, gap);
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic drain();
    while (outs_seen != sent_cnt) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic report(input string name, input int n, input int base);
    $display("%s: %0d groups, %0d errors", name, n, errors_now() - base);
  endtask

  task automatic check_output();
    alpha_group_t e;
    if (OUT_CREDITS + credits_seen - outs_seen <= 0) begin
      $display("output %0d was sent while downstream held no credit", outs_seen);
      chk_errs++;
    end
    if (outs_seen >= exp_q.size()) begin
      $display("output %0d arrived with no group outstanding", outs_seen);
      chk_errs++;
    end else begin
      e = expected_at(outs_seen);
      if (out_group.count != e.count) begin
        $display("MISMATCH group %0d o_out_group.count got %h expected %h",
                 outs_seen, out_group.count, e.count);
        chk_errs++;
      end
      for (int i = 0; i < NUM_NODES; i++) begin
        if (out_group.alpha[i] != e.alpha[i]) begin
          $display("MISMATCH group %0d o_out_group.alpha[%0d] got %h expected %h",
                   outs_seen, i, out_group.alpha[i], e.alpha[i]);
          chk_errs++;
        end
      end
    end
    outs_seen++;
  endtask

  // scoreboard, samples mid-cycle once outputs have settled
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (in_credit) in_credits_rcvd++;
        if (out_valid) check_output();
        if (out_credit) credits_seen++;
      end
    end
  end

  // downstream returns one credit per result after a random delay
  initial begin
    int unsigned delay;
    delay = 0;
    out_credit = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      out_credit = 1'b0;
      if (rst_n && !hold_credits && (outs_seen > credits_sent)) begin
        if (delay == 0) begin
          out_credit = 1'b1;
          credits_sent++;
          if (prompt_credits) delay = 0;
          else take_bits(cred_lfsr, 3, delay);
        end else begin
          delay--;
        end
      end
    end
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("run did not finish within %0d cycles, the DUT appears to hang", WD_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    coef_group_t  g;
    alpha_group_t e;
    int unsigned  v;
    int           base;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_group = '0;
    hold_credits = 1'b0;
    prompt_credits = 1'b0;
    stim_lfsr = LFSR_SEED;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    base = errors_now();
    for (int k = 0; k < N_SINGLE; k++) begin
      random_group(1, 1'b0, g);
      e = '0;
      e.count = 1;
      e.alpha[0] = ALPHA_W'(1 << ALPHA_FRAC);
      send_group(g, e, 1'b1);
    end
    drain();
    report("single node", N_SINGLE, base);

    base = errors_now();
    for (int k = 0; k < N_FULL; k++) begin
      random_group(NUM_NODES, 1'b0, g);
      send_group(g, ref_alpha(g), 1'b1);
    end
    drain();
    report("full groups", N_FULL, base);

    base = errors_now();
    for (int k = 0; k < N_PART; k++) begin
      take_bits(stim_lfsr, 3, v);
      random_group(int'(v) + 1, 1'b0, g);
      send_group(g, ref_alpha(g), 1'b1);
    end
    drain();
    report("partial counts", N_PART, base);

    // equal terms split 1.0 evenly
    base = errors_now();
    for (int k = 0; k < N_EQUAL; k++) begin
      random_group(k + 1, 1'b1, g);
      e = '0;
      e.count = NODE_CNT_W'(k + 1);
      for (int i = 0; i <= k; i++) e.alpha[i] = ALPHA_W'((1 << ALPHA_FRAC) / (k + 1));
      send_group(g, e, 1'b1);
    end
    drain();
    report("equal coefficients", N_EQUAL, base);

    base = errors_now();
    hold_credits = 1'b1;
    fork
      begin
        for (int k = 0; k < N_BP; k++) begin
          take_bits(stim_lfsr, 3, v);
          random_group(int'(v) + 1, 1'b0, g);
          send_group(g, ref_alpha(g), 1'b0);
        end
      end
      begin
        repeat (BP_HOLD) @(posedge clk);
        #1;
        hold_credits = 1'b0;
      end
    join
    drain();
    if (in_credits_rcvd != sent_cnt) begin
      $display("upstream got %0d credits back for %0d groups sent", in_credits_rcvd, sent_cnt);
      stim_errs++;
    end
    report("back-pressure", N_BP, base);

    base = errors_now();
    prompt_credits = 1'b1;
    for (int k = 0; k < N_B2B; k++) begin
      take_bits(stim_lfsr, 3, v);
      random_group(int'(v) + 1, 1'b0, g);
      send_group(g, ref_alpha(g), 1'b0);
    end
    drain();
    report("back-to-back", N_B2B, base);

    $display("groups sent %0d, results %0d, errors %0d", sent_cnt, outs_seen, errors_now());
    if (errors_now() == 0 && outs_seen == N_TOTAL) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+tb
common/softmax_pkg.sv
logic/coef_ingress.sv
softmax/fxp_div_pipe.sv
softmax/softmax_engine.sv
logic/alpha_egress.sv
logic/gat_softmax_top.sv
tb/tb_gat_softmax.sv

//--- run_sim.sh
#!/bin/sh
# build and run the softmax testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_gat_softmax \
  -f tb.f -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status, see sim.log"
  exit 1
fi

if grep -q "^TEST OK$" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1
